/* rtl/fp_pkg.sv */
`default_nettype none

package fp_pkg;

    localparam int fp_word_width = 32;
    localparam int exp_width     = 8;
    localparam int frac_width    = 23;

    localparam logic [exp_width-1:0]     exp_bias  = 8'd127;
    localparam logic [exp_width-1:0]     exp_max   = 8'hFF;
    localparam logic [fp_word_width-1:0] qnan_word = 32'h7FC0_0000;

    // IEEE 754 binary32 layout, sign in the top bit.
    typedef struct packed {
        logic                  sign;
        logic [exp_width-1:0]  exp;
        logic [frac_width-1:0] frac;
    } fp_fields_t;

    // Bit order matches status bits 8 down to 4.
    typedef struct packed {
        logic invalid;
        logic qnan_res;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    typedef enum logic [4:0] {
        op_add = 5'd16,
        op_sub = 5'd17,
        op_mul = 5'd18,
        op_nop = 5'd22,
        op_slt = 5'd23
    } fp_op_t;

endpackage

`default_nettype wire

/* rtl/regmap_pkg.sv */
`default_nettype none

package regmap_pkg;

    localparam int axi_addr_width = 5;
    localparam int axi_data_width = 32;

    localparam logic [axi_addr_width-1:0] reg_opa    = 5'h00;
    localparam logic [axi_addr_width-1:0] reg_opb    = 5'h04;
    localparam logic [axi_addr_width-1:0] reg_ctrl   = 5'h08;
    localparam logic [axi_addr_width-1:0] reg_status = 5'h0C;
    localparam logic [axi_addr_width-1:0] reg_result = 5'h10;

    localparam int ctrl_op_lsb = 0;  // Opcode sits in bits 4 to 0.
    localparam int ctrl_go_bit = 8;

    localparam int status_busy_bit  = 0;
    localparam int status_done_bit  = 1;
    localparam int status_flags_lsb = 4;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* rtl/fpu_if.sv */
`default_nettype none

interface fpu_if;
    import fp_pkg::*;

    fp_fields_t opa;
    fp_fields_t opb;
    fp_op_t     op;
    logic       start;  // One cycle per issued operation.

    logic [fp_word_width-1:0] result;
    fp_flags_t                flags;
    logic                     done;

    modport csr (
        output opa, opb, op, start,
        input  result, flags, done
    );

    modport core (
        input  opa, opb, op, start,
        output result, flags, done
    );

endinterface

`default_nettype wire

/* rtl/fpu_csr.sv */
`default_nettype none

module fpu_csr (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [regmap_pkg::axi_addr_width-1:0]   s_axi_awaddr,
    input  logic                                    s_axi_awvalid,
    output logic                                    s_axi_awready,
    input  logic [regmap_pkg::axi_data_width-1:0]   s_axi_wdata,
    input  logic [regmap_pkg::axi_data_width/8-1:0] s_axi_wstrb,
    input  logic                                    s_axi_wvalid,
    output logic                                    s_axi_wready,
    output logic [1:0]                              s_axi_bresp,
    output logic                                    s_axi_bvalid,
    input  logic                                    s_axi_bready,
    input  logic [regmap_pkg::axi_addr_width-1:0]   s_axi_araddr,
    input  logic                                    s_axi_arvalid,
    output logic                                    s_axi_arready,
    output logic [regmap_pkg::axi_data_width-1:0]   s_axi_rdata,
    output logic [1:0]                              s_axi_rresp,
    output logic                                    s_axi_rvalid,
    input  logic                                    s_axi_rready,
    fpu_if.csr                                      bus
);
    import regmap_pkg::*;
    import fp_pkg::*;

    logic                        aw_hold;
    logic                        w_hold;
    logic [axi_addr_width-1:0]   awaddr_q;
    logic [axi_data_width-1:0]   wdata_q;
    logic [axi_data_width/8-1:0] wstrb_q;
    logic                        aw_fire;
    logic                        w_fire;
    logic                        have_aw;
    logic                        have_w;
    logic                        wr_commit;
    logic                        bvalid_nxt;
    logic                        ar_fire;
    logic                        rvalid_nxt;
    logic [axi_addr_width-1:0]   wr_addr;
    logic [axi_data_width-1:0]   wr_data;
    logic [axi_data_width/8-1:0] wr_strb;
    logic [axi_data_width-1:0]   ctrl_wr;
    logic [axi_data_width-1:0]   rd_word;
    logic                        wr_err;
    logic                        rd_err;
    logic                        issue;
    logic                        op_ok;
    fp_fields_t                  opa_q;
    fp_fields_t                  opb_q;
    logic [axi_data_width-1:0]   ctrl_q;
    logic [axi_data_width-1:0]   result_q;
    fp_op_t                      op_q;
    fp_flags_t                   flags_q;
    logic                        busy;
    logic                        done_q;

    function automatic logic [axi_data_width-1:0] merge_bytes(
        input logic [axi_data_width-1:0]   old_word,
        input logic [axi_data_width-1:0]   new_word,
        input logic [axi_data_width/8-1:0] strb
    );
        logic [axi_data_width-1:0] word;
        word = old_word;
        for (int i = 0; i < axi_data_width / 8; i++) begin
            if (strb[i]) word[8*i +: 8] = new_word[8*i +: 8];
        end
        return word;
    endfunction

    // Address and data may come in either order, the write lands when both are here.
    assign aw_fire    = s_axi_awvalid && s_axi_awready;
    assign w_fire     = s_axi_wvalid && s_axi_wready;
    assign have_aw    = aw_hold || aw_fire;
    assign have_w     = w_hold || w_fire;
    assign wr_commit  = have_aw && have_w;
    assign bvalid_nxt = wr_commit || (s_axi_bvalid && !s_axi_bready);
    assign wr_addr    = aw_hold ? awaddr_q : s_axi_awaddr;
    assign wr_data    = w_hold ? wdata_q : s_axi_wdata;
    assign wr_strb    = w_hold ? wstrb_q : s_axi_wstrb;
    assign ctrl_wr    = merge_bytes(ctrl_q, wr_data, wr_strb);

    assign bus.opa = opa_q;
    assign bus.opb = opb_q;
    assign bus.op  = op_q;

    always_comb begin
        case (ctrl_wr[ctrl_op_lsb +: $bits(fp_op_t)])
            op_add, op_sub, op_mul, op_nop, op_slt: op_ok = 1'b1;
            default: op_ok = 1'b0;
        endcase
        wr_err = 1'b1;
        issue  = 1'b0;
        case (wr_addr)
            reg_opa, reg_opb: wr_err = 1'b0;
            reg_ctrl: begin
                if (!ctrl_wr[ctrl_go_bit]) begin
                    wr_err = 1'b0;
                end else if (!busy && op_ok) begin
                    wr_err = 1'b0;
                    issue  = 1'b1;
                end
            end
            default: wr_err = 1'b1;  // Status, result and holes are not writable.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_hold       <= 1'b0;
            w_hold        <= 1'b0;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_bresp   <= resp_okay;
        end else begin
            aw_hold       <= have_aw && !wr_commit;
            w_hold        <= have_w && !wr_commit;
            s_axi_awready <= !(have_aw && !wr_commit) && !bvalid_nxt;
            s_axi_wready  <= !(have_w && !wr_commit) && !bvalid_nxt;
            s_axi_bvalid  <= bvalid_nxt;
            if (wr_commit) s_axi_bresp <= wr_err ? resp_slverr : resp_okay;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) awaddr_q <= s_axi_awaddr;
        if (w_fire) begin
            wdata_q <= s_axi_wdata;
            wstrb_q <= s_axi_wstrb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa_q     <= '0;
            opb_q     <= '0;
            ctrl_q    <= '0;
            op_q      <= op_nop;
            result_q  <= '0;
            flags_q   <= '0;
            busy      <= 1'b0;
            done_q    <= 1'b0;
            bus.start <= 1'b0;
        end else begin
            bus.start <= wr_commit && issue;
            if (wr_commit && !wr_err) begin
                case (wr_addr)
                    reg_opa: opa_q <= merge_bytes(opa_q, wr_data, wr_strb);
                    reg_opb: opb_q <= merge_bytes(opb_q, wr_data, wr_strb);
                    reg_ctrl: begin
                        ctrl_q              <= ctrl_wr;
                        ctrl_q[ctrl_go_bit] <= 1'b0;  // Go is a command and reads back as 0.
                    end
                    default: ;
                endcase
            end
            if (wr_commit && issue) begin
                op_q   <= fp_op_t'(ctrl_wr[ctrl_op_lsb +: $bits(fp_op_t)]);
                busy   <= 1'b1;
                done_q <= 1'b0;
            end else if (bus.done) begin
                result_q <= bus.result;
                flags_q  <= bus.flags;
                busy     <= 1'b0;
                done_q   <= 1'b1;
            end
        end
    end

    assign ar_fire    = s_axi_arvalid && s_axi_arready;
    assign rvalid_nxt = ar_fire || (s_axi_rvalid && !s_axi_rready);

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (s_axi_araddr)
            reg_opa:    rd_word = opa_q;
            reg_opb:    rd_word = opb_q;
            reg_ctrl:   rd_word = ctrl_q;
            reg_result: rd_word = result_q;
            reg_status: begin
                rd_word[status_busy_bit]                         = busy;
                rd_word[status_done_bit]                         = done_q;
                rd_word[status_flags_lsb +: $bits(fp_flags_t)]   = flags_q;
            end
            default: rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rdata   <= '0;
            s_axi_rresp   <= resp_okay;
        end else begin
            s_axi_rvalid  <= rvalid_nxt;
            s_axi_arready <= !rvalid_nxt;
            if (ar_fire) begin
                s_axi_rdata <= rd_word;  // Held while rready is low.
                s_axi_rresp <= rd_err ? resp_slverr : resp_okay;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fp_addsub.sv */
`default_nettype none

module fp_addsub (
    input  fp_pkg::fp_fields_t a,
    input  fp_pkg::fp_fields_t b,
    input  logic               subtract,
    output fp_pkg::fp_fields_t result,
    output fp_pkg::fp_flags_t  flags
);
    import fp_pkg::*;

    fp_fields_t              b_eff;
    fp_fields_t              big;
    fp_fields_t              little;
    logic [exp_width-1:0]    exp_diff;
    logic [2*frac_width+1:0] small_ext;
    logic [frac_width:0]     small_man;
    logic                    lost;
    logic [frac_width+1:0]   man_sum;
    logic [frac_width:0]     man_norm;
    logic [4:0]              lz;

    always_comb begin
        b_eff      = b;
        b_eff.sign = b.sign ^ subtract;

        // The larger magnitude leads, so the difference never goes negative.
        if ({a.exp, a.frac} >= {b.exp, b.frac}) begin
            big    = a;
            little = b_eff;
        end else begin
            big    = b_eff;
            little = a;
        end

        exp_diff  = big.exp - little.exp;
        small_ext = {1'b1, little.frac, {(frac_width + 1){1'b0}}} >> exp_diff;
        small_man = small_ext[2*frac_width+1 -: frac_width+1];
        lost      = (|small_ext[frac_width:0]) || (exp_diff > 8'd47);  // Bits shifted off.

        if (big.sign == little.sign) begin
            man_sum = {2'b01, big.frac} + {1'b0, small_man};
        end else begin
            man_sum = {2'b01, big.frac} - {1'b0, small_man};
        end

        lz = '0;
        for (int i = 0; i <= frac_width; i++) begin
            if (man_sum[i]) lz = 5'(frac_width - i);  // Highest set bit wins.
        end
        man_norm = man_sum[frac_width:0] << lz;

        flags = '0;
        if ({b.exp, b.frac} == '0) begin
            result = a;
        end else if ({a.exp, a.frac} == '0) begin
            result = b_eff;
        end else if (man_sum == '0) begin
            result = '0;  // Exact cancellation is +0.
        end else if (man_sum[frac_width+1]) begin
            flags.inexact = lost || man_sum[0];
            if (big.exp >= exp_max - 8'd1) begin
                flags.overflow = 1'b1;
                result         = {big.sign, exp_max, {frac_width{1'b0}}};
            end else begin
                result = {big.sign, big.exp + 8'd1, man_sum[frac_width:1]};
            end
        end else begin
            flags.inexact = lost;
            if ({3'b000, lz} >= big.exp) begin
                flags.underflow = 1'b1;
                result          = {big.sign, {(exp_width + frac_width){1'b0}}};
            end else begin
                result = {big.sign, big.exp - {3'b000, lz}, man_norm[frac_width-1:0]};
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fp_mul.sv */
`default_nettype none

module fp_mul (
    input  fp_pkg::fp_fields_t a,
    input  fp_pkg::fp_fields_t b,
    output fp_pkg::fp_fields_t result,
    output fp_pkg::fp_flags_t  flags
);
    import fp_pkg::*;

    logic                    sign;
    logic                    sticky;
    logic [2*frac_width+1:0] product;
    logic [frac_width:0]     man;
    logic [exp_width+1:0]    exp_adj;
    logic [exp_width+1:0]    exp_n;

    always_comb begin
        sign    = a.sign ^ b.sign;
        product = {1'b1, a.frac} * {1'b1, b.frac};
        exp_adj = {2'b00, a.exp} + {2'b00, b.exp};

        // A product of 2.0 or more needs one right shift.
        if (product[2*frac_width+1]) begin
            man     = product[2*frac_width+1 -: frac_width+1];
            sticky  = |product[frac_width:0];
            exp_adj = exp_adj + 10'd1;
        end else begin
            man    = product[2*frac_width -: frac_width+1];
            sticky = |product[frac_width-1:0];
        end
        exp_n = exp_adj - {2'b00, exp_bias};

        flags = '0;
        if ({a.exp, a.frac} == '0 || {b.exp, b.frac} == '0) begin
            result = {sign, {(exp_width + frac_width){1'b0}}};
        end else if (exp_adj <= {2'b00, exp_bias}) begin
            flags.underflow = 1'b1;
            flags.inexact   = sticky;
            result          = {sign, {(exp_width + frac_width){1'b0}}};
        end else if (exp_n >= {2'b00, exp_max}) begin
            flags.overflow = 1'b1;
            flags.inexact  = sticky;
            result         = {sign, exp_max, {frac_width{1'b0}}};
        end else begin
            flags.inexact = sticky;
            result        = {sign, exp_n[exp_width-1:0], man[frac_width-1:0]};
        end
    end

endmodule

`default_nettype wire

/* rtl/fpu_core.sv */
`default_nettype none

module fpu_core (
    input logic clk,
    input logic rst_n,
    fpu_if.core bus
);
    import fp_pkg::*;

    fp_fields_t a_q;
    fp_fields_t b_q;
    fp_op_t     op_q;
    logic       valid_q;
    fp_fields_t add_res;
    fp_fields_t mul_res;
    fp_flags_t  add_flags;
    fp_flags_t  mul_flags;
    fp_fields_t res_d;
    fp_flags_t  flags_d;
    logic       a_nan;
    logic       b_nan;
    logic       inf_times_zero;
    logic       a_lt_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            op_q    <= op_nop;
        end else begin
            valid_q <= bus.start;
            if (bus.start) op_q <= bus.op;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            a_q <= bus.opa;
            b_q <= bus.opb;
        end
    end

    fp_addsub u_addsub (
        .a        (a_q),
        .b        (b_q),
        .subtract (op_q == op_sub),
        .result   (add_res),
        .flags    (add_flags)
    );

    fp_mul u_mul (
        .a      (a_q),
        .b      (b_q),
        .result (mul_res),
        .flags  (mul_flags)
    );

    assign a_nan = (a_q.exp == exp_max) && (a_q.frac != '0);
    assign b_nan = (b_q.exp == exp_max) && (b_q.frac != '0);
    // A NaN paired with zero is already invalid, so only the exponent is checked.
    assign inf_times_zero = ((a_q.exp == exp_max) && ({b_q.exp, b_q.frac} == '0)) ||
                            ((b_q.exp == exp_max) && ({a_q.exp, a_q.frac} == '0));

    always_comb begin
        if (a_q.sign != b_q.sign) begin
            a_lt_b = a_q.sign;
        end else if (!a_q.sign) begin
            a_lt_b = {a_q.exp, a_q.frac} < {b_q.exp, b_q.frac};
        end else begin
            a_lt_b = {a_q.exp, a_q.frac} > {b_q.exp, b_q.frac};  // Two negatives order backwards.
        end
    end

    always_comb begin
        flags_d = '0;
        if (op_q == op_nop) begin
            res_d = a_q;
        end else if (op_q == op_slt) begin
            res_d = fp_fields_t'({{(fp_word_width - 1){1'b0}}, a_lt_b});
        end else if (a_nan || b_nan || (op_q == op_mul && inf_times_zero)) begin
            res_d           = qnan_word;
            flags_d.invalid = 1'b1;
        end else if (op_q == op_mul) begin
            res_d   = mul_res;
            flags_d = mul_flags;
        end else begin
            res_d   = add_res;
            flags_d = add_flags;
        end
        if (!flags_d.invalid && res_d.exp == exp_max && res_d.frac != '0) begin
            flags_d.qnan_res = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            bus.result <= res_d;
            bus.flags  <= flags_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/fpu_top.sv */
`default_nettype none

module fpu_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [regmap_pkg::axi_addr_width-1:0]   s_axi_awaddr,
    input  logic                                    s_axi_awvalid,
    output logic                                    s_axi_awready,
    input  logic [regmap_pkg::axi_data_width-1:0]   s_axi_wdata,
    input  logic [regmap_pkg::axi_data_width/8-1:0] s_axi_wstrb,
    input  logic                                    s_axi_wvalid,
    output logic                                    s_axi_wready,
    output logic [1:0]                              s_axi_bresp,
    output logic                                    s_axi_bvalid,
    input  logic                                    s_axi_bready,
    input  logic [regmap_pkg::axi_addr_width-1:0]   s_axi_araddr,
    input  logic                                    s_axi_arvalid,
    output logic                                    s_axi_arready,
    output logic [regmap_pkg::axi_data_width-1:0]   s_axi_rdata,
    output logic [1:0]                              s_axi_rresp,
    output logic                                    s_axi_rvalid,
    input  logic                                    s_axi_rready
);

    fpu_if bus ();

    fpu_csr u_csr (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .bus           (bus.csr)
    );

    fpu_core u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.core)
    );

endmodule

`default_nettype wire

/* verification/tb_fpu.sv */
`default_nettype none

module tb_fpu;
    import regmap_pkg::*;

    localparam logic [4:0] opc_add = 5'd16;
    localparam logic [4:0] opc_sub = 5'd17;
    localparam logic [4:0] opc_mul = 5'd18;
    localparam logic [4:0] opc_nop = 5'd22;
    localparam logic [4:0] opc_slt = 5'd23;

    // Status flag bits from invalid down to inexact.
    localparam logic [4:0] fl_invalid  = 5'b10000;
    localparam logic [4:0] fl_qnan     = 5'b01000;
    localparam logic [4:0] fl_overflow = 5'b00100;
    localparam logic [4:0] fl_inexact  = 5'b00001;

    localparam int max_cycles = 4000;  // Twice about 50 operations of under 40 cycles each.

    logic                        clk;
    logic                        rst_n;
    logic [axi_addr_width-1:0]   s_axi_awaddr;
    logic                        s_axi_awvalid;
    logic                        s_axi_awready;
    logic [axi_data_width-1:0]   s_axi_wdata;
    logic [axi_data_width/8-1:0] s_axi_wstrb;
    logic                        s_axi_wvalid;
    logic                        s_axi_wready;
    logic [1:0]                  s_axi_bresp;
    logic                        s_axi_bvalid;
    logic                        s_axi_bready;
    logic [axi_addr_width-1:0]   s_axi_araddr;
    logic                        s_axi_arvalid;
    logic                        s_axi_arready;
    logic [axi_data_width-1:0]   s_axi_rdata;
    logic [1:0]                  s_axi_rresp;
    logic                        s_axi_rvalid;
    logic                        s_axi_rready;

    int cycle  = 0;  // Number of rising edges so far.
    int errors = 0;
    int checks = 0;
    int b_edge;
    int ar_edge;

    fpu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", max_cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s: expected %08h, actual %08h", name, exp, got);
            errors++;
        end
    endtask

    // Bus tasks start right after a rising edge and return right after one.
    task automatic write_reg(input logic [axi_addr_width-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic aw_pending;
        logic w_pending;
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= '1;
        s_axi_wvalid  <= 1'b1;
        s_axi_bready  <= 1'b1;
        aw_pending = 1'b1;
        w_pending  = 1'b1;
        while (aw_pending || w_pending) begin
            @(negedge clk);
            if (s_axi_awready) aw_pending = 1'b0;  // Taken on the coming edge.
            if (s_axi_wready) w_pending = 1'b0;
            @(posedge clk);
            if (!aw_pending) s_axi_awvalid <= 1'b0;
            if (!w_pending) s_axi_wvalid <= 1'b0;
        end
        do @(negedge clk); while (!s_axi_bvalid);
        resp   = s_axi_bresp;
        b_edge = cycle;
        @(posedge clk);
        s_axi_bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [axi_addr_width-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        s_axi_rready  <= 1'b1;
        do @(negedge clk); while (!s_axi_arready);
        ar_edge = cycle + 1;
        @(posedge clk);
        s_axi_arvalid <= 1'b0;
        do @(negedge clk); while (!s_axi_rvalid);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        @(posedge clk);
    endtask

    // The read address is accepted exactly on the target edge.
    task automatic read_at_edge(input logic [axi_addr_width-1:0] addr, input int target,
                                output logic [31:0] data);
        logic [1:0] resp;
        @(negedge clk);
        while (cycle < target - 2) @(negedge clk);
        @(posedge clk);
        read_reg(addr, data, resp);
        assert (ar_edge == target) else begin
            $display("Timed read landed on edge %0d instead of edge %0d", ar_edge, target);
            errors++;
        end
    endtask

    task automatic wait_done(input string name, output logic [31:0] status);
        logic [1:0] resp;
        int         polls;
        polls = 0;
        do begin
            read_reg(reg_status, status, resp);
            polls++;
        end while (!status[status_done_bit] && polls < 20);
        assert (status[status_done_bit]) else begin
            $display("%s: the done bit never appeared in the status word", name);
            errors++;
        end
    endtask

    function automatic logic [31:0] go_word(input logic [4:0] op);
        return (32'd1 << ctrl_go_bit) | {27'd0, op};
    endfunction

    task automatic check_op(input string name, input logic [4:0] op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] exp_res,
                            input logic [4:0] exp_flags);
        logic [1:0]  resp;
        logic [31:0] status;
        logic [31:0] res;
        write_reg(reg_opa, a, resp);
        write_reg(reg_opb, b, resp);
        write_reg(reg_ctrl, go_word(op), resp);
        check_val({name, " go response"}, {30'd0, resp_okay}, {30'd0, resp});
        wait_done(name, status);
        read_reg(reg_result, res, resp);
        check_val(name, exp_res, res);
        check_val({name, " flags"}, {27'd0, exp_flags}, {27'd0, status[status_flags_lsb +: 5]});
    endtask

    // Encodes v times 2 to the power e when the magnitude of v is below 2 to the 24.
    function automatic logic [31:0] to_float(input longint v, input int e);
        logic [31:0] w;
        longint      mag;
        int          msb;
        if (v == 0) return 32'h0;
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 40; i++) begin
            if (mag[i]) msb = i;
        end
        w[31]    = (v < 0);
        w[30:23] = 8'(msb + e + 127);
        w[22:0]  = 23'(mag << (23 - msb));
        return w;
    endfunction

    function automatic logic slt_ref(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31]) return a[31];
        if (a[30:23] != b[30:23]) begin
            return a[31] ? (a[30:23] > b[30:23]) : (a[30:23] < b[30:23]);
        end
        return a[31] ? (a[22:0] > b[22:0]) : (a[22:0] < b[22:0]);
    endfunction

    initial begin
        logic [31:0] data;
        logic [31:0] held;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  exp_flags;
        logic [1:0]  resp;
        longint      ma;
        longint      mb;
        longint      sa;
        longint      sb;
        int          ea;
        int          eb;
        int          emin;
        void'($urandom(32'h50ce));
        rst_n         <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(reg_status, data, resp);
        check_val("status after reset", 32'd0, data);
        a = $urandom;
        b = $urandom;
        write_reg(reg_opa, a, resp);
        check_val("opa write response", {30'd0, resp_okay}, {30'd0, resp});
        write_reg(reg_opb, b, resp);
        read_reg(reg_opa, data, resp);
        check_val("opa readback", a, data);
        read_reg(reg_opb, data, resp);
        check_val("opb readback", b, data);
        write_reg(reg_result, 32'h1234_5678, resp);
        check_val("result write response", {30'd0, resp_slverr}, {30'd0, resp});
        read_reg(5'h14, data, resp);
        check_val("undefined read data", 32'd0, data);
        check_val("undefined read response", {30'd0, resp_slverr}, {30'd0, resp});

        // Read of opa with rready held low for a while.
        s_axi_araddr  <= reg_opa;
        s_axi_arvalid <= 1'b1;
        s_axi_rready  <= 1'b0;
        do @(negedge clk); while (!s_axi_arready);
        @(posedge clk);
        s_axi_arvalid <= 1'b0;
        do @(negedge clk); while (!s_axi_rvalid);
        held = s_axi_rdata;
        repeat (4) begin
            @(negedge clk);
            check_val("stalled rvalid", 32'd1, {31'd0, s_axi_rvalid});
            check_val("stalled rdata", held, s_axi_rdata);
        end
        @(posedge clk);
        s_axi_rready <= 1'b1;
        @(posedge clk);
        check_val("stalled read value", a, held);

        check_op("add 1.5 + 2.25", opc_add, 32'h3FC0_0000, 32'h4010_0000, 32'h4070_0000, 5'd0);
        check_op("sub 1.0 - 3.0", opc_sub, 32'h3F80_0000, 32'h4040_0000, 32'hC000_0000, 5'd0);
        a = to_float(longint'($urandom_range(255, 1)), 3);
        check_op("sub x - x", opc_sub, a, a, 32'h0, 5'd0);
        check_op("add 2^24 + 1.0", opc_add, 32'h4B80_0000, 32'h3F80_0000, 32'h4B80_0000,
                 fl_inexact);
        check_op("add max + max", opc_add, 32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000,
                 fl_overflow);
        check_op("mul inf * 0", opc_mul, 32'h7F80_0000, 32'h0, 32'h7FC0_0000, fl_invalid);
        check_op("mul nan * 1.0", opc_mul, 32'h7FA0_0001, 32'h3F80_0000, 32'h7FC0_0000,
                 fl_invalid);

        for (int n = 0; n < 6; n++) begin
            ma = longint'($urandom_range(255, 1));
            mb = longint'($urandom_range(255, 1));
            if ($urandom_range(1, 0) == 1) ma = -ma;
            if ($urandom_range(1, 0) == 1) mb = -mb;
            ea   = int'($urandom_range(8, 0)) - 4;
            eb   = int'($urandom_range(8, 0)) - 4;
            emin = (ea < eb) ? ea : eb;
            a    = to_float(ma, ea);
            b    = to_float(mb, eb);
            sa   = ma * (longint'(1) << (ea - emin));  // Both on the scale of the smaller exponent.
            sb   = mb * (longint'(1) << (eb - emin));
            check_op($sformatf("exact add %0d", n), opc_add, a, b, to_float(sa + sb, emin), 5'd0);
            check_op($sformatf("exact sub %0d", n), opc_sub, a, b, to_float(sa - sb, emin), 5'd0);
            check_op($sformatf("exact mul %0d", n), opc_mul, a, b, to_float(ma * mb, ea + eb),
                     5'd0);
        end

        for (int n = 0; n < 3; n++) begin
            a = (n == 2) ? 32'h7FC0_1234 : $urandom;
            b = $urandom;
            exp_flags = (a[30:23] == 8'hFF && a[22:0] != 0) ? fl_qnan : 5'd0;
            check_op($sformatf("nop %0d", n), opc_nop, a, b, a, exp_flags);
        end

        for (int n = 0; n < 12; n++) begin
            a = $urandom;
            b = $urandom;
            if (n % 3 == 1) b[31:23] = a[31:23];  // The fraction decides.
            if (n % 4 == 3) b[31] = a[31];
            if (n == 11) b = a;
            check_op($sformatf("slt %0d", n), opc_slt, a, b, {31'd0, slt_ref(a, b)}, 5'd0);
        end

        write_reg(reg_opa, 32'h3FC0_0000, resp);
        write_reg(reg_opb, 32'h4010_0000, resp);
        write_reg(reg_ctrl, go_word(opc_add), resp);
        check_val("first go response", {30'd0, resp_okay}, {30'd0, resp});
        write_reg(reg_ctrl, go_word(opc_mul), resp);
        check_val("go while busy response", {30'd0, resp_slverr}, {30'd0, resp});
        wait_done("go while busy", data);
        read_reg(reg_result, data, resp);
        check_val("result after busy go", 32'h4070_0000, data);
        // With operand B at 3.0 any issued operation would change the result.
        write_reg(reg_opb, 32'h4040_0000, resp);
        write_reg(reg_ctrl, go_word(5'd19), resp);
        check_val("bad opcode response", {30'd0, resp_slverr}, {30'd0, resp});
        read_reg(reg_status, data, resp);
        check_val("status after bad opcode", 32'd2, {30'd0, data[1:0]});
        read_reg(reg_result, data, resp);
        check_val("result after bad opcode", 32'h4070_0000, data);

        // Done lands on the third edge after bvalid of the go write.
        write_reg(reg_ctrl, go_word(opc_mul), resp);
        check_val("timed go response", {30'd0, resp_okay}, {30'd0, resp});
        read_at_edge(reg_status, b_edge + 3, data);
        check_val("status on third edge", 32'd1, {30'd0, data[1:0]});
        write_reg(reg_ctrl, go_word(opc_mul), resp);
        check_val("second timed go response", {30'd0, resp_okay}, {30'd0, resp});
        read_at_edge(reg_status, b_edge + 4, data);
        check_val("status after third edge", 32'd2, {30'd0, data[1:0]});
        read_reg(reg_result, data, resp);
        check_val("mul 1.5 * 3.0", 32'h4090_0000, data);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/fp_pkg.sv
rtl/regmap_pkg.sv
rtl/fpu_if.sv
rtl/fpu_csr.sv
rtl/fp_addsub.sv
rtl/fp_mul.sv
rtl/fpu_core.sv
rtl/fpu_top.sv
verification/tb_fpu.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_fpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
